// File: design/div_pkg.sv
package div_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoding seen by the divider
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Value of the 4-bit instruction type that routes an instruction here.
    localparam logic [3:0] DIV_TYPE = 4'd2;

    // Subtype values 0 to 3 select the operation.
    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,   // Signed quotient.
        OP_MOD  = 2'd1,   // Signed remainder.
        OP_DIVU = 2'd2,   // Unsigned quotient.
        OP_MODU = 2'd3    // Unsigned remainder.
    } div_op_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode to core control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // The sign flags are only ever set for the signed operations, so the core
    // can apply its sign fixups without looking at the operation again.
    typedef struct packed {
        logic    start;          // A request is presented this cycle.
        div_op_t op;
        logic    dividend_neg;   // Dividend was negative.
        logic    divisor_neg;    // Divisor was negative.
    } div_ctrl_t;

    // True for the two operations that return the quotient.
    function automatic logic op_is_quotient(div_op_t op);
        return (op == OP_DIV) || (op == OP_DIVU);
    endfunction

    // True for the two operations that treat operands as two's complement.
    function automatic logic op_is_signed(div_op_t op);
        return (op == OP_DIV) || (op == OP_MOD);
    endfunction

endpackage

// File: design/leading_one.sv
`timescale 1ns/1ps

// Priority encoder for the highest set bit of a word.
module leading_one #(
    parameter int WIDTH = 32
) (
    input  logic [WIDTH-1:0]         din,
    output logic [$clog2(WIDTH)-1:0] pos
);

    localparam int IW = $clog2(WIDTH);

    logic [WIDTH-1:0] win;   // Remaining search window, right aligned.

    // Each level asks whether anything is set in the upper half of the
    // current window. If so that half becomes the new window and the level
    // contributes a one to the position. Bits above the window are always
    // zero, so shifting the upper half down keeps the test simple.
    always_comb
    begin
        win = din;
        pos = '0;
        for (int lvl = IW - 1; lvl >= 0; lvl--)
        begin
            if (|(win >> (1 << lvl)))
            begin
                pos[lvl] = 1'b1;
                win      = win >> (1 << lvl);
            end
            else
            begin
                pos[lvl] = 1'b0;
            end
        end
    end

    // A zero input and an input of one both give position 0.

endmodule

// File: design/div_decode.sv
`timescale 1ns/1ps

module div_decode
    import div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic [3:0]       div_type,
    input  logic [4:0]       div_subtype,
    input  logic             flush_issue,
    input  logic [WIDTH-1:0] din1,
    input  logic [WIDTH-1:0] din2,
    output div_ctrl_t        ctrl,
    output logic [WIDTH-1:0] dividend_mag,
    output logic [WIDTH-1:0] divisor_mag
);

    div_op_t op;
    logic    subtype_ok;
    logic    signed_op;

    // Only subtypes 0 to 3 name an operation.
    assign subtype_ok = (div_subtype[4:2] == 3'b000);
    assign op         = div_op_t'(div_subtype[1:0]);
    assign signed_op  = op_is_signed(op);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request and sign capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        ctrl.start        = (div_type == DIV_TYPE) && subtype_ok && !flush_issue;
        ctrl.op           = op;
        ctrl.dividend_neg = signed_op && din1[WIDTH-1];
        ctrl.divisor_neg  = signed_op && din2[WIDTH-1];
    end

    // The core works on magnitudes only.
    always_comb
    begin
        if (ctrl.dividend_neg)
            dividend_mag = '0 - din1;
        else
            dividend_mag = din1;

        if (ctrl.divisor_neg)
            divisor_mag = '0 - din2;
        else
            divisor_mag = din2;
    end

    // The most negative value negates to itself, which as an unsigned
    // magnitude is still the right number.

endmodule

// File: design/div_core.sv
`timescale 1ns/1ps

module div_core
    import div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  div_ctrl_t        ctrl,
    input  logic [WIDTH-1:0] dividend_mag,
    input  logic [WIDTH-1:0] divisor_mag,
    input  logic             flush_wb,
    input  logic             stall_wb,
    output logic             stall,
    output logic [WIDTH-1:0] dout
);

    localparam int IW = $clog2(WIDTH);
    localparam int CW = IW + 1;   // Room for a negative shift.

    typedef enum logic [1:0] {
        S_IDLE  = 2'd0,
        S_ALIGN = 2'd1,
        S_DIV   = 2'd2,
        S_DONE  = 2'd3
    } state_t;

    state_t                 state_q, state_d;
    div_op_t                op_q, op_d;
    logic                   dividend_neg_q, dividend_neg_d;
    logic                   divisor_neg_q, divisor_neg_d;
    logic [WIDTH-1:0]       divisor_q, divisor_d;
    logic [WIDTH-1:0]       rem_q, rem_d;
    logic [WIDTH-1:0]       quo_q, quo_d;
    logic signed [CW-1:0]   count_q, count_d;

    logic [IW-1:0]          lead_rem;
    logic [IW-1:0]          lead_div;
    logic signed [CW-1:0]   align_shift;
    logic [WIDTH:0]         trial;
    logic [WIDTH-1:0]       rem_step;
    logic [WIDTH-1:0]       quo_step;

    leading_one #(.WIDTH(WIDTH)) u_lead_rem (.din(rem_q),     .pos(lead_rem));
    leading_one #(.WIDTH(WIDTH)) u_lead_div (.din(divisor_q), .pos(lead_div));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath of one iteration
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // Distance between the top bits of remainder and divisor.
    assign align_shift = signed'({1'b0, lead_rem}) - signed'({1'b0, lead_div});

    // The aligned divisor never has a bit above the dividend's top bit, so
    // the extra bit of the trial is purely its borrow.
    assign trial    = {1'b0, rem_q} - ({1'b0, divisor_q} << count_q[CW-2:0]);
    assign rem_step = trial[WIDTH] ? rem_q : trial[WIDTH-1:0];
    assign quo_step = {quo_q[WIDTH-2:0], ~trial[WIDTH]};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State machine
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb
    begin
        state_d        = state_q;
        op_d           = op_q;
        dividend_neg_d = dividend_neg_q;
        divisor_neg_d  = divisor_neg_q;
        divisor_d      = divisor_q;
        rem_d          = rem_q;
        quo_d          = quo_q;
        count_d        = count_q;

        case (state_q)
            S_IDLE:
            begin
                if (ctrl.start)
                begin
                    op_d           = ctrl.op;
                    dividend_neg_d = ctrl.dividend_neg;
                    divisor_neg_d  = ctrl.divisor_neg;
                    divisor_d      = divisor_mag;
                    rem_d          = dividend_mag;
                    quo_d          = '0;
                    count_d        = '0;
                    if (divisor_mag == '0)
                    begin
                        state_d = S_DONE;   // Remainder is the dividend itself.
                        if (ctrl.dividend_neg)
                            rem_d = '0 - dividend_mag;
                    end
                    else
                    begin
                        state_d = S_ALIGN;
                    end
                end
            end
            S_ALIGN:
            begin
                count_d = align_shift;
                if (align_shift < 0)
                begin
                    // Dividend smaller than divisor.
                    state_d = S_DONE;
                    quo_d   = '0;
                    if (dividend_neg_q)
                        rem_d = '0 - rem_q;
                end
                else
                begin
                    state_d = S_DIV;
                end
            end
            S_DIV:
            begin
                rem_d = rem_step;
                quo_d = quo_step;
                if (count_q == '0)
                begin
                    state_d = S_DONE;
                    if (dividend_neg_q)
                        rem_d = '0 - rem_step;
                    if (dividend_neg_q ^ divisor_neg_q)
                        quo_d = '0 - quo_step;
                end
                else
                begin
                    count_d = count_q - 1'b1;
                end
            end
            S_DONE:
            begin
                if (!stall_wb)
                    state_d = S_IDLE;
            end
            default:
            begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset || flush_wb)
        begin
            state_q        <= S_IDLE;
            op_q           <= OP_DIV;
            dividend_neg_q <= 1'b0;
            divisor_neg_q  <= 1'b0;
            divisor_q      <= '0;
            rem_q          <= '0;
            quo_q          <= '0;
            count_q        <= '0;
        end
        else
        begin
            state_q        <= state_d;
            op_q           <= op_d;
            dividend_neg_q <= dividend_neg_d;
            divisor_neg_q  <= divisor_neg_d;
            divisor_q      <= divisor_d;
            rem_q          <= rem_d;
            quo_q          <= quo_d;
            count_q        <= count_d;
        end
    end

    assign stall = (state_q == S_ALIGN) || (state_q == S_DIV);
    assign dout  = op_is_quotient(op_q) ? quo_q : rem_q;   // Held until next accept.

endmodule

// File: design/div_unit.sv
`timescale 1ns/1ps

module div_unit
    import div_pkg::*;
#(
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             reset,
    input  logic [3:0]       div_type,
    input  logic [4:0]       div_subtype,
    input  logic             flush_issue,
    input  logic             flush_wb,
    input  logic             stall_wb,
    input  logic [WIDTH-1:0] din1,
    input  logic [WIDTH-1:0] din2,
    output logic             stall,
    output logic [WIDTH-1:0] dout
);

    div_ctrl_t        ctrl;
    logic [WIDTH-1:0] dividend_mag;
    logic [WIDTH-1:0] divisor_mag;

    // Request recognition and operand magnitudes.
    div_decode #(.WIDTH(WIDTH)) u_div_decode (
        .div_type     (div_type),
        .div_subtype  (div_subtype),
        .flush_issue  (flush_issue),
        .din1         (din1),
        .din2         (din2),
        .ctrl         (ctrl),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag)
    );

    div_core #(.WIDTH(WIDTH)) u_div_core (
        .clk          (clk),
        .reset        (reset),
        .ctrl         (ctrl),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .flush_wb     (flush_wb),
        .stall_wb     (stall_wb),
        .stall        (stall),
        .dout         (dout)
    );

endmodule

// File: verification/tb_div_vectors.svh
`ifndef TB_DIV_VECTORS_SVH
`define TB_DIV_VECTORS_SVH

// Each row holds type, subtype, flush_issue, din1, din2, the stall_wb hold cycles,
// the flush_wb delay in cycles after the accept edge and the expected dout.
localparam logic [7:0] NO_FLUSH = 8'hff;

typedef struct packed {
    logic [3:0]  op_type;
    logic [4:0]  subtype;       // 0 div, 1 mod, 2 divu, 3 modu.
    logic        flush_issue;
    logic [31:0] din1;
    logic [31:0] din2;
    logic [7:0]  hold;
    logic [7:0]  flush_dly;
    logic [31:0] expected;
} vec_t;

localparam int NUM_VECS = 23;

vec_t vectors [NUM_VECS] = '{
    '{DIV_TYPE, 5'd0, 1'b0, 32'd100,       32'd7,         8'd0, NO_FLUSH, 32'h0000000e},
    '{DIV_TYPE, 5'd1, 1'b0, 32'd100,       32'd7,         8'd0, NO_FLUSH, 32'h00000002},
    '{DIV_TYPE, 5'd0, 1'b0, 32'hffffff9c,  32'd7,         8'd0, NO_FLUSH, 32'hfffffff2},
    '{DIV_TYPE, 5'd1, 1'b0, 32'hffffff9c,  32'd7,         8'd0, NO_FLUSH, 32'hfffffffe},
    '{DIV_TYPE, 5'd0, 1'b0, 32'd100,       32'hfffffff9,  8'd0, NO_FLUSH, 32'hfffffff2},
    '{DIV_TYPE, 5'd1, 1'b0, 32'd100,       32'hfffffff9,  8'd0, NO_FLUSH, 32'h00000002},
    '{DIV_TYPE, 5'd0, 1'b0, 32'hffffff9c,  32'hfffffff9,  8'd0, NO_FLUSH, 32'h0000000e},
    '{DIV_TYPE, 5'd1, 1'b0, 32'hffffff9c,  32'hfffffff9,  8'd0, NO_FLUSH, 32'hfffffffe},
    '{DIV_TYPE, 5'd0, 1'b0, 32'h80000000,  32'hffffffff,  8'd0, NO_FLUSH, 32'h80000000},
    '{DIV_TYPE, 5'd1, 1'b0, 32'h80000000,  32'hffffffff,  8'd0, NO_FLUSH, 32'h00000000},
    '{DIV_TYPE, 5'd2, 1'b0, 32'hffffffff,  32'h00000010,  8'd0, NO_FLUSH, 32'h0fffffff},
    '{DIV_TYPE, 5'd3, 1'b0, 32'hffffffff,  32'h00000010,  8'd0, NO_FLUSH, 32'h0000000f},
    '{DIV_TYPE, 5'd2, 1'b0, 32'h12345678,  32'h9abcdef0,  8'd0, NO_FLUSH, 32'h00000000},
    '{DIV_TYPE, 5'd3, 1'b0, 32'h12345678,  32'h9abcdef0,  8'd0, NO_FLUSH, 32'h12345678},
    '{DIV_TYPE, 5'd0, 1'b0, 32'h7fffffff,  32'h00000000,  8'd0, NO_FLUSH, 32'h00000000},
    '{DIV_TYPE, 5'd1, 1'b0, 32'hfffffffb,  32'h00000000,  8'd0, NO_FLUSH, 32'hfffffffb},
    '{DIV_TYPE, 5'd0, 1'b0, 32'd1000,      32'd3,         8'd3, NO_FLUSH, 32'h0000014d},
    '{DIV_TYPE, 5'd3, 1'b0, 32'd1000,      32'd3,         8'd2, NO_FLUSH, 32'h00000001},
    '{DIV_TYPE, 5'd0, 1'b1, 32'd50,        32'd5,         8'd0, NO_FLUSH, 32'h00000001},
    '{4'd3,     5'd2, 1'b0, 32'd50,        32'd5,         8'd0, NO_FLUSH, 32'h00000001},
    '{DIV_TYPE, 5'd2, 1'b0, 32'hffffffff,  32'h00000001,  8'd0, 8'd5,     32'h00000000},
    '{DIV_TYPE, 5'd0, 1'b1, 32'd9,         32'd3,         8'd0, NO_FLUSH, 32'h00000000},
    '{DIV_TYPE, 5'd6, 1'b0, 32'd9,         32'd3,         8'd0, NO_FLUSH, 32'h00000000}
};

`endif

// File: verification/tb_div_unit.sv
`timescale 1ns/1ps

module tb_div_unit
    import div_pkg::*;
();

    localparam int WIDTH      = 32;
    localparam int TIMEOUT    = 100;
    localparam int NUM_RANDOM = 40;

    logic             clk;
    logic             reset;
    logic [3:0]       div_type;
    logic [4:0]       div_subtype;
    logic             flush_issue;
    logic             flush_wb;
    logic             stall_wb;
    logic [WIDTH-1:0] din1;
    logic [WIDTH-1:0] din2;
    logic             stall;
    logic [WIDTH-1:0] dout;

    integer           seed;
    int               checks;
    int               errors;
    int               timeouts;

    `include "tb_div_vectors.svh"

    vec_t             rand_vec;

    div_unit #(.WIDTH(WIDTH)) u_div_unit (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model and checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 64-bit arithmetic keeps the most negative value over -1 in range.
    function automatic logic [31:0] model_result(input div_op_t op, input logic [31:0] a,
                                                 input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic [63:0]        q;
        logic [63:0]        r;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        if (b == 32'd0)
        begin
            q = 64'd0;
            r = {32'd0, a};
        end
        else if (op == OP_DIV || op == OP_MOD)
        begin
            q = sa / sb;   // Truncates toward zero.
            r = sa % sb;
        end
        else
        begin
            q = {32'd0, a} / {32'd0, b};
            r = {32'd0, a} % {32'd0, b};
        end
        return (op == OP_DIV || op == OP_DIVU) ? q[31:0] : r[31:0];
    endfunction

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else
        begin
            errors++;
            $display("error: %s = %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Presents one request, waits for the result and checks it.
    task automatic run_row(input vec_t v);
        logic busy;
        int   waited;
        busy = (v.op_type == DIV_TYPE) && (v.subtype[4:2] == 3'b000) && !v.flush_issue
            && (v.din2 != 32'd0);
        @(posedge clk);
        div_type    <= v.op_type;
        div_subtype <= v.subtype;
        flush_issue <= v.flush_issue;
        din1        <= v.din1;
        din2        <= v.din2;
        stall_wb    <= (v.hold != 8'd0);
        @(posedge clk);                 // Accept edge.
        div_type    <= 4'd0;
        flush_issue <= 1'b0;
        @(negedge clk);
        check_word("stall", {31'd0, stall}, {31'd0, busy});
        if (v.flush_dly != NO_FLUSH)
        begin
            repeat (int'(v.flush_dly) + 1) @(posedge clk);
            flush_wb <= 1'b1;
            @(posedge clk);
            flush_wb <= 1'b0;
            @(negedge clk);
            check_word("stall", {31'd0, stall}, 32'd0);
        end
        waited = 0;
        while (stall !== 1'b0 && waited < TIMEOUT)
        begin
            @(negedge clk);
            waited++;
        end
        if (stall !== 1'b0)
        begin
            timeouts++;
            $display("timeout: stall stayed high for %0d cycles after a request", TIMEOUT);
        end
        else
        begin
            check_word("dout", dout, v.expected);
            for (int n = 0; n < int'(v.hold); n++)
            begin
                @(posedge clk);
                @(negedge clk);
                check_word("stall", {31'd0, stall}, 32'd0);
                check_word("dout", dout, v.expected);   // Held while stall_wb is high.
            end
            if (v.hold != 8'd0)
            begin
                @(posedge clk);
                stall_wb <= 1'b0;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial
    begin
        logic [31:0] rnd;
        seed        = 32'h94747972;
        checks      = 0;
        errors      = 0;
        timeouts    = 0;
        reset       = 1'b1;
        div_type    = 4'd0;
        div_subtype = 5'd0;
        flush_issue = 1'b0;
        flush_wb    = 1'b0;
        stall_wb    = 1'b0;
        din1        = '0;
        din2        = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_word("stall", {31'd0, stall}, 32'd0);
        check_word("dout", dout, 32'd0);

        for (int i = 0; i < NUM_VECS && timeouts == 0; i++)
            run_row(vectors[i]);

        for (int i = 0; i < NUM_RANDOM && timeouts == 0; i++)
        begin
            rnd                  = $random(seed);
            rand_vec.op_type     = DIV_TYPE;
            rand_vec.subtype     = {3'b000, rnd[1:0]};
            rand_vec.flush_issue = 1'b0;
            rand_vec.din1        = $random(seed);
            rand_vec.din2        = $random(seed);
            if (i % 2 == 1)
                rand_vec.din2 = rand_vec.din2 >> rnd[6:2];   // Larger quotients.
            rand_vec.hold        = 8'd0;
            rand_vec.flush_dly   = NO_FLUSH;
            rand_vec.expected    = model_result(div_op_t'(rnd[1:0]), rand_vec.din1,
                                                rand_vec.din2);
            run_row(rand_vec);
        end

        $display("checks: %0d, value errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

// File: filelist.f
+incdir+verification
design/div_pkg.sv
design/leading_one.sv
design/div_decode.sv
design/div_core.sv
design/div_unit.sv
verification/tb_div_unit.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_div_unit -f filelist.f \
    && ./obj_dir/Vtb_div_unit > sim.log 2>&1 \
    || { echo "Build or simulation failed."; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
